/* Makefile */
TOP = tb_from_pc

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP)
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	@if grep -q "sim failed" sim.log; then echo "Simulation FAILED"; exit 1; fi
	@grep -q "sim passed" sim.log || (echo "No pass line in log"; exit 1)

clean:
	rm -rf obj_dir sim.log

/* sim.f */
src/from_pc_pkg.sv
src/completion_router.sv
src/read_request_arbiter.sv
src/sync_fwft_fifo.sv
src/from_pc_channel.sv
src/from_pc_top.sv
testbench/tb_from_pc.sv

/* src/completion_router.sv */
`timescale 1ns/1ps

module completion_router import from_pc_pkg::*; (
   input  logic                                 clock,
   input  logic                                 i_rst,
   input  logic                                 i_rc_valid,
   input  rd_tag_t                              i_rc_tag,
   input  logic [INDEX_BITS-1:0]                i_rc_index,
   input  logic [DATA_BITS-1:0]                 i_rc_data,
   output completion_t [NUM_CHANNELS-1:0]       o_cpl
);

   // Per-channel valid bits, decoded from the tag as the beat is registered.
   logic [NUM_CHANNELS-1:0] hit_q;
   rd_tag_t                 tag_q;
   logic [INDEX_BITS-1:0]   index_q;
   logic [DATA_BITS-1:0]    data_q;

   always_ff @(posedge clock) begin
      if (i_rst) begin
         hit_q <= '0;
      end else begin
         for (int c = 0; c < NUM_CHANNELS; c++) begin
            hit_q[c] <= i_rc_valid && (i_rc_tag.chan == CHAN_BITS'(c));
         end
      end
   end

   // The beat itself is only captured when valid, so idle cycles leave it alone.
   always_ff @(posedge clock) begin
      if (i_rc_valid) begin
         tag_q   <= i_rc_tag;
         index_q <= i_rc_index;
         data_q  <= i_rc_data;
      end
   end

   // Every channel sees the same beat.
   // Only the owner sees valid, so channels never look at the channel field.
   always_comb begin
      for (int c = 0; c < NUM_CHANNELS; c++) begin
         o_cpl[c].valid = hit_q[c];
         o_cpl[c].tag   = tag_q;
         o_cpl[c].index = index_q;
         o_cpl[c].data  = data_q;
      end
   end

   // At most one channel sees a valid beat in any cycle.
   a_one_owner: assert property (@(posedge clock) disable iff (i_rst)
      $onehot0(hit_q))
      else $error("completion routed to more than one channel");

endmodule

/* src/from_pc_channel.sv */
`timescale 1ns/1ps

module from_pc_channel import from_pc_pkg::*; (
   input  logic                  clock,
   input  logic                  i_rst,
   input  completion_t           i_cpl,
   input  logic                  i_grant,
   output logic                  o_req_want,
   output logic [BLOCK_BITS-1:0] o_req_block,
   input  logic                  i_fifo_read,
   output logic [DATA_BITS-1:0]  o_fifo_data,
   output logic                  o_fifo_valid
);

   // Reorder RAM, addressed by block in the upper bits and word index below.
   logic [DATA_BITS-1:0]     reorder_ram [2**RAM_ADDR_BITS];
   logic [RAM_ADDR_BITS-1:0] wr_addr;
   logic [DATA_BITS-1:0]     ram_q;
   logic [DATA_BITS-1:0]     stage_q;

   // One flag per block, set by the last beat and cleared as the write pointer passes.
   logic [2**BLOCK_BITS-1:0] block_filled;

   // Blocks from p_write up to p_request are requested but not complete.
   // Blocks from the read block up to p_write are complete but not drained.
   logic [BLOCK_BITS-1:0]    p_write;
   logic [BLOCK_BITS-1:0]    p_request;
   logic [RAM_ADDR_BITS-1:0] p_read;
   logic [BLOCK_BITS-1:0]    read_block;
   logic [BLOCK_BITS-1:0]    n_requested;
   logic [BLOCK_BITS-1:0]    n_in_use;
   logic [HOLDOFF_BITS-1:0]  holdoff;

   logic write_last;
   logic read_step;
   logic fifo_ready;
   logic stage_valid_0;
   logic stage_valid_1;

   ////////////////////
   // Completion side
   ////////////////////

   assign wr_addr    = {i_cpl.tag.block, i_cpl.index};
   assign write_last = i_cpl.valid && (i_cpl.index == INDEX_BITS'(2**INDEX_BITS - 1));

   // Beats are written where they belong, whatever order the host returns them in.
   always_ff @(posedge clock) begin
      if (i_cpl.valid) begin
         reorder_ram[wr_addr] <= i_cpl.data;
      end
      ram_q <= reorder_ram[p_read];
   end

   always_ff @(posedge clock) begin
      if (i_rst) begin
         block_filled <= '0;
      end else begin
         for (int b = 0; b < 2**BLOCK_BITS; b++) begin
            if (write_last && (i_cpl.tag.block == BLOCK_BITS'(b))) begin
               block_filled[b] <= 1'b1;
            end else if (p_write == BLOCK_BITS'(b)) begin
               block_filled[b] <= 1'b0;
            end
         end
      end
   end

   // The write pointer only moves past a full block, which keeps release in request order.
   always_ff @(posedge clock) begin
      if (i_rst) begin
         p_write <= '0;
      end else if (block_filled[p_write]) begin
         p_write <= p_write + 1'b1;
      end
   end

   ////////////////////
   // Request side
   ////////////////////

   assign read_block  = p_read[RAM_ADDR_BITS-1:INDEX_BITS];
   assign n_requested = p_request - p_write;
   assign n_in_use    = p_request - read_block;

   // A request needs a quiet holdoff and room under the credit limit.
   // It also may not land on a block that is still being read out.
   assign o_req_want = (holdoff == '0)
                    && (n_requested < BLOCK_BITS'(MAX_OUTSTANDING))
                    && (n_in_use < BLOCK_BITS'(2**BLOCK_BITS - 1));
   assign o_req_block = p_request;

   always_ff @(posedge clock) begin
      if (i_rst) begin
         p_request <= '0;
         holdoff   <= '0;
      end else if (i_grant) begin
         p_request <= p_request + 1'b1;
         holdoff   <= HOLDOFF_BITS'(HOLDOFF_CYCLES);
      end else if (holdoff != '0) begin
         holdoff <= holdoff - 1'b1;
      end
   end

   ////////////////////
   // Drain side
   ////////////////////

   // Step through complete blocks one word per cycle while the FIFO has room.
   assign read_step = (read_block != p_write) && fifo_ready;

   always_ff @(posedge clock) begin
      if (i_rst) begin
         p_read        <= '0;
         stage_valid_0 <= 1'b0;
         stage_valid_1 <= 1'b0;
      end else begin
         if (read_step) begin
            p_read <= p_read + 1'b1;
         end
         stage_valid_0 <= read_step;
         stage_valid_1 <= stage_valid_0;
      end
   end

   // Staging register, which lines the word up with stage_valid_1.
   always_ff @(posedge clock) begin
      stage_q <= ram_q;
   end

   sync_fwft_fifo i_sync_fwft_fifo (
      .clock   (clock),
      .i_rst   (i_rst),
      .i_data  (stage_q),
      .i_valid (stage_valid_1),
      .o_ready (fifo_ready),
      .i_read  (i_fifo_read),
      .o_data  (o_fifo_data),
      .o_valid (o_fifo_valid)
   );

   // The host only answers tags it was given, so beats target requested blocks.
   a_cpl_in_span: assert property (@(posedge clock) disable iff (i_rst)
      i_cpl.valid |-> (BLOCK_BITS'(i_cpl.tag.block - p_write) < n_requested))
      else $error("completion for a block that is not outstanding");

endmodule

/* src/from_pc_pkg.sv */
package from_pc_pkg;

   ////////////////////
   // Sizes
   ////////////////////

   // Four channels share the read request port and the completion port.
   localparam int NUM_CHANNELS = 4;
   localparam int CHAN_BITS = 2;

   // Each channel has eight 512 byte blocks of 64 words each.
   localparam int BLOCK_BITS = 3;
   localparam int INDEX_BITS = 6;
   localparam int DATA_BITS = 64;
   localparam int RAM_ADDR_BITS = BLOCK_BITS + INDEX_BITS;

   // A channel never has more than six blocks in flight toward the host.
   localparam int MAX_OUTSTANDING = 6;

   // Quiet cycles a channel keeps after each accepted request.
   localparam int HOLDOFF_CYCLES = 3;
   localparam int HOLDOFF_BITS = 2;

   // Output FIFO geometry.
   // Ready drops while fewer than FIFO_SPARE entries are free.
   localparam int FIFO_ADDR_BITS = 4;
   localparam int FIFO_DEPTH = 1 << FIFO_ADDR_BITS;
   localparam int FIFO_SPARE = 3;

   ////////////////////
   // Types
   ////////////////////

   // A read tag names the channel in its upper bits and the block below.
   typedef struct packed {
      logic [CHAN_BITS-1:0]  chan;
      logic [BLOCK_BITS-1:0] block;
   } rd_tag_t;

   // One completion beat as delivered to a channel.
   typedef struct packed {
      logic                  valid;
      rd_tag_t               tag;
      logic [INDEX_BITS-1:0] index;
      logic [DATA_BITS-1:0]  data;
   } completion_t;

   // The read request shown to the host.
   typedef struct packed {
      logic    valid;
      rd_tag_t tag;
   } rd_request_t;

endpackage

/* src/from_pc_top.sv */
`timescale 1ns/1ps

module from_pc_top import from_pc_pkg::*; (
   input  logic                                  clock,
   input  logic                                  i_rst,
   input  logic                                  i_rc_valid,
   input  rd_tag_t                               i_rc_tag,
   input  logic [INDEX_BITS-1:0]                 i_rc_index,
   input  logic [DATA_BITS-1:0]                  i_rc_data,
   output rd_request_t                           o_rr,
   input  logic                                  i_rr_ready,
   input  logic [NUM_CHANNELS-1:0]               i_fifo_read,
   output logic [NUM_CHANNELS-1:0][DATA_BITS-1:0] o_fifo_data,
   output logic [NUM_CHANNELS-1:0]               o_fifo_valid
);

   completion_t [NUM_CHANNELS-1:0]                cpl;
   logic [NUM_CHANNELS-1:0]                       req_want;
   logic [NUM_CHANNELS-1:0]                       grant;
   logic [NUM_CHANNELS-1:0][BLOCK_BITS-1:0]       req_block;

   // Completions from the link fan out to the channel named in the tag.
   completion_router i_completion_router (
      .clock      (clock),
      .i_rst      (i_rst),
      .i_rc_valid (i_rc_valid),
      .i_rc_tag   (i_rc_tag),
      .i_rc_index (i_rc_index),
      .i_rc_data  (i_rc_data),
      .o_cpl      (cpl)
   );

   // Read requests from all channels share one port to the host.
   read_request_arbiter i_read_request_arbiter (
      .clock       (clock),
      .i_rst       (i_rst),
      .i_req_want  (req_want),
      .i_req_block (req_block),
      .i_rr_ready  (i_rr_ready),
      .o_rr        (o_rr),
      .o_grant     (grant)
   );

   for (genvar c = 0; c < NUM_CHANNELS; c++) begin : g_channel
      from_pc_channel i_from_pc_channel (
         .clock        (clock),
         .i_rst        (i_rst),
         .i_cpl        (cpl[c]),
         .i_grant      (grant[c]),
         .o_req_want   (req_want[c]),
         .o_req_block  (req_block[c]),
         .i_fifo_read  (i_fifo_read[c]),
         .o_fifo_data  (o_fifo_data[c]),
         .o_fifo_valid (o_fifo_valid[c])
      );
   end

endmodule

/* src/read_request_arbiter.sv */
`timescale 1ns/1ps

module read_request_arbiter import from_pc_pkg::*; (
   input  logic                                  clock,
   input  logic                                  i_rst,
   input  logic [NUM_CHANNELS-1:0]               i_req_want,
   input  logic [NUM_CHANNELS-1:0][BLOCK_BITS-1:0] i_req_block,
   input  logic                                  i_rr_ready,
   output rd_request_t                           o_rr,
   output logic [NUM_CHANNELS-1:0]               o_grant
);

   // The round-robin pointer names the channel searched first.
   logic [CHAN_BITS-1:0] rr_ptr;
   logic [CHAN_BITS-1:0] pick_chan;
   logic                 pick_found;
   logic                 rr_valid;
   rd_tag_t              rr_tag;

   ////////////////////
   // Selection
   ////////////////////

   // Search upward from the pointer and take the first wanting channel.
   // The cast wraps the search index back to channel zero.
   always_comb begin
      pick_found = 1'b0;
      pick_chan  = rr_ptr;
      for (int k = 0; k < NUM_CHANNELS; k++) begin
         if (!pick_found && i_req_want[CHAN_BITS'(rr_ptr + k)]) begin
            pick_found = 1'b1;
            pick_chan  = CHAN_BITS'(rr_ptr + k);
         end
      end
   end

   ////////////////////
   // Request register
   ////////////////////

   // A shown request stays put until the host accepts it.
   // After an acceptance the register goes empty for a cycle.
   // The granted channel's want has dropped by then.
   always_ff @(posedge clock) begin
      if (i_rst) begin
         rr_valid <= 1'b0;
         rr_ptr   <= '0;
      end else if (i_rr_ready) begin
         rr_valid <= 1'b0;
         rr_ptr   <= rr_tag.chan + 1'b1;
      end else if (!rr_valid && pick_found) begin
         rr_valid <= 1'b1;
      end
   end

   always_ff @(posedge clock) begin
      if (!rr_valid && pick_found) begin
         rr_tag.chan  <= pick_chan;
         rr_tag.block <= i_req_block[pick_chan];
      end
   end

   assign o_rr.valid = rr_valid;
   assign o_rr.tag   = rr_tag;

   // The grant goes out in the acceptance cycle so the channel steps on the same edge.
   always_comb begin
      o_grant = '0;
      if (i_rr_ready && rr_valid) begin
         o_grant[rr_tag.chan] = 1'b1;
      end
   end

   a_ready_with_valid: assert property (@(posedge clock) disable iff (i_rst)
      i_rr_ready |-> rr_valid)
      else $error("request accepted while none was shown");

   // A grant names at most one channel, and only one that still wants to issue.
   a_grant_owner: assert property (@(posedge clock) disable iff (i_rst)
      $onehot0(o_grant) && ((o_grant & ~i_req_want) == '0))
      else $error("grant to more than one channel or to one that does not want");

endmodule

/* src/sync_fwft_fifo.sv */
`timescale 1ns/1ps

module sync_fwft_fifo import from_pc_pkg::*; (
   input  logic                 clock,
   input  logic                 i_rst,
   input  logic [DATA_BITS-1:0] i_data,
   input  logic                 i_valid,
   output logic                 o_ready,
   input  logic                 i_read,
   output logic [DATA_BITS-1:0] o_data,
   output logic                 o_valid
);

   logic [DATA_BITS-1:0]      mem [FIFO_DEPTH];
   logic [FIFO_ADDR_BITS-1:0] wr_ptr;
   logic [FIFO_ADDR_BITS-1:0] rd_ptr;
   logic [FIFO_ADDR_BITS:0]   count;
   logic                      do_write;
   logic                      do_read;
   logic                      full;

   // The writer is trusted to respect o_ready, so a valid word is always stored.
   assign do_write = i_valid;
   assign do_read  = i_read && o_valid;
   assign full     = count == (FIFO_ADDR_BITS+1)'(FIFO_DEPTH);

   always_ff @(posedge clock) begin
      if (do_write) begin
         mem[wr_ptr] <= i_data;
      end
   end

   always_ff @(posedge clock) begin
      if (i_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_write) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_read) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_write, do_read})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // The head word is presented whenever anything is stored.
   assign o_data  = mem[rd_ptr];
   assign o_valid = count != '0;

   // Ready leaves room for the words still in the writer's pipeline.
   assign o_ready = count <= (FIFO_ADDR_BITS+1)'(FIFO_DEPTH - FIFO_SPARE);

   a_no_overflow: assert property (@(posedge clock) disable iff (i_rst)
      i_valid |-> !full)
      else $error("write into a full FIFO");

endmodule

/* testbench/tb_from_pc.sv */
`timescale 1ns/1ps

module tb_from_pc import from_pc_pkg::*; ();

   localparam int CLK_PERIOD = 100;
   localparam int RESET_CYCLES = 4;
   localparam int BEATS = 2**INDEX_BITS;
   localparam int BLOCKS_PER_CHAN = 20;
   localparam int STALL_START = 600;
   localparam int STALL_CYCLES = 3000;
   localparam int MARGIN_CYCLES = 2000;
   // Two cycles per beat cover the shared completion port.
   // The stall adds its own length.
   localparam int WATCHDOG_CYCLES = BLOCKS_PER_CHAN * NUM_CHANNELS * BEATS * 2
                                  + STALL_CYCLES + MARGIN_CYCLES;

   // A tag the host has accepted and still owes data for.
   typedef struct packed {
      logic [CHAN_BITS-1:0]  chan;
      logic [15:0]           seq;
      logic [BLOCK_BITS-1:0] block;
   } pending_t;

   logic                                   clock;
   logic                                   i_rst;
   logic                                   i_rc_valid;
   rd_tag_t                                i_rc_tag;
   logic [INDEX_BITS-1:0]                  i_rc_index;
   logic [DATA_BITS-1:0]                   i_rc_data;
   rd_request_t                            o_rr;
   logic                                   i_rr_ready;
   logic [NUM_CHANNELS-1:0]                i_fifo_read;
   logic [NUM_CHANNELS-1:0][DATA_BITS-1:0] o_fifo_data;
   logic [NUM_CHANNELS-1:0]                o_fifo_valid;

   logic [31:0]             lfsr_state = 32'hdba2_85f0;
   int                      cycle;
   pending_t                pending[$];
   logic                    slot_busy[2];
   pending_t                slot_tag[2];
   int                      slot_idx[2];
   int                      req_seq[NUM_CHANNELS];
   int                      rd_seq[NUM_CHANNELS];
   int                      rd_idx[NUM_CHANNELS];
   int                      last_accept[NUM_CHANNELS];
   int                      passes[NUM_CHANNELS][NUM_CHANNELS];
   int                      frozen_req;
   int                      words_at_mid[NUM_CHANNELS];
   logic [NUM_CHANNELS-1:0] want_snap;
   logic [NUM_CHANNELS-1:0] load_want;
   logic                    prev_rr_valid;

   from_pc_top i_from_pc_top (
      .clock        (clock),
      .i_rst        (i_rst),
      .i_rc_valid   (i_rc_valid),
      .i_rc_tag     (i_rc_tag),
      .i_rc_index   (i_rc_index),
      .i_rc_data    (i_rc_data),
      .o_rr         (o_rr),
      .i_rr_ready   (i_rr_ready),
      .i_fifo_read  (i_fifo_read),
      .o_fifo_data  (o_fifo_data),
      .o_fifo_valid (o_fifo_valid)
   );

   always #(CLK_PERIOD/2) clock = ~clock;

   ////////////////////
   // Helpers
   ////////////////////

   // Fibonacci LFSR with taps 32, 22, 2 and 1, stepped once per bit taken.
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
         lfsr_state = {lfsr_state[30:0], fb};
         r = {r[30:0], fb};
      end
      return r;
   endfunction

   // Each beat says where it came from, so the expected stream follows from counters.
   function automatic logic [DATA_BITS-1:0] beat_word(input int chan, input int seq,
                                                      input int idx);
      return {32'(chan), 16'(seq), 16'(idx)};
   endfunction

   task automatic report_error(input string msg);
      $display("Mismatch at %0t ns: %s", $time, msg);
      $display("sim failed");
      $fatal(1, "stopping at the first error");
   endtask

   function automatic logic all_done();
      for (int c = 0; c < NUM_CHANNELS; c++) begin
         if (rd_seq[c] < BLOCKS_PER_CHAN) begin
            return 1'b0;
         end
      end
      return 1'b1;
   endfunction

   ////////////////////
   // Host model
   ////////////////////

   task automatic drive_cycle();
      int       c;
      int       sel;
      int       pick;
      logic     rd;
      logic     stalled;
      pending_t p;
      i_rr_ready = 1'b0;
      i_rc_valid = 1'b0;

      // Drain side. A word shown now with read high is taken at the next edge.
      stalled = (cycle >= STALL_START) && (cycle < STALL_START + STALL_CYCLES);
      for (int k = 0; k < NUM_CHANNELS; k++) begin
         rd = |take_bits(1);
         if (k == 0 && stalled) begin
            rd = 1'b0;
         end
         if (rd && o_fifo_valid[k]) begin
            assert (o_fifo_data[k] == beat_word(k, rd_seq[k], rd_idx[k]))
               else report_error($sformatf("channel %0d read %h, expected block %0d word %0d",
                                           k, o_fifo_data[k], rd_seq[k], rd_idx[k]));
            rd_idx[k]++;
            if (rd_idx[k] == BEATS) begin
               rd_idx[k] = 0;
               rd_seq[k]++;
            end
         end
         i_fifo_read[k] = rd;
      end

      // Completion side, with up to two tags interleaved.
      if (take_bits(2) != 0) begin
         sel = take_bits(1);
         if (!slot_busy[sel] && pending.size() > 0) begin
            pick = take_bits(5) % pending.size();
            slot_tag[sel]  = pending[pick];
            slot_idx[sel]  = 0;
            slot_busy[sel] = 1'b1;
            pending.delete(pick);
         end
         if (slot_busy[sel]) begin
            p = slot_tag[sel];
            i_rc_valid       = 1'b1;
            i_rc_tag.chan    = p.chan;
            i_rc_tag.block   = p.block;
            i_rc_index       = INDEX_BITS'(slot_idx[sel]);
            i_rc_data        = beat_word(int'(p.chan), int'(p.seq), slot_idx[sel]);
            slot_idx[sel]++;
            if (slot_idx[sel] == BEATS) begin
               slot_busy[sel] = 1'b0;
            end
         end
      end

      // Request side. A newly shown tag must respect the channel's holdoff.
      if (o_rr.valid && !prev_rr_valid) begin
         load_want = want_snap;
         c = int'(o_rr.tag.chan);
         assert (cycle - last_accept[c] > HOLDOFF_CYCLES)
            else report_error($sformatf("channel %0d shown %0d cycles after its acceptance",
                                        c, cycle - last_accept[c]));
      end
      if (!o_rr.valid) begin
         want_snap = i_from_pc_top.req_want;
      end
      prev_rr_valid = o_rr.valid;

      if (o_rr.valid && take_bits(1)) begin
         c = int'(o_rr.tag.chan);
         i_rr_ready = 1'b1;
         assert (o_rr.tag.block == BLOCK_BITS'(req_seq[c]))
            else report_error($sformatf("channel %0d tag block %0d, expected %0d",
                                        c, o_rr.tag.block, req_seq[c] % 8));
         // A channel that kept wanting may lose to the same winner only once.
         for (int o = 0; o < NUM_CHANNELS; o++) begin
            if (o != c && load_want[o]) begin
               passes[o][c]++;
               assert (passes[o][c] <= 1)
                  else report_error($sformatf("channel %0d passed over twice by channel %0d",
                                              o, c));
            end else if (o != c) begin
               for (int g = 0; g < NUM_CHANNELS; g++) begin
                  passes[o][g] = 0;
               end
            end
         end
         for (int g = 0; g < NUM_CHANNELS; g++) begin
            passes[c][g] = 0;
         end
         last_accept[c] = cycle + 1;
         if (req_seq[c] < BLOCKS_PER_CHAN) begin
            p.chan  = CHAN_BITS'(c);
            p.seq   = 16'(req_seq[c]);
            p.block = o_rr.tag.block;
            pending.push_back(p);
         end
         req_seq[c]++;
      end

      // Seven blocks fit in the reorder RAM.
      // One more may sit partly in the FIFO.
      for (int k = 0; k < NUM_CHANNELS; k++) begin
         assert (req_seq[k] - rd_seq[k] <= MAX_OUTSTANDING + 2)
            else report_error($sformatf("channel %0d has %0d blocks unread",
                                        k, req_seq[k] - rd_seq[k]));
      end
   endtask

   ////////////////////
   // Sequence
   ////////////////////

   initial begin
      clock       = 1'b0;
      i_rst       = 1'b1;
      i_rc_valid  = 1'b0;
      i_rc_tag    = '0;
      i_rc_index  = '0;
      i_rc_data   = '0;
      i_rr_ready  = 1'b0;
      i_fifo_read = '0;
      cycle         = 0;
      prev_rr_valid = 1'b0;
      want_snap     = '0;
      load_want     = '0;
      slot_busy     = '{1'b0, 1'b0};
      for (int c = 0; c < NUM_CHANNELS; c++) begin
         req_seq[c]     = 0;
         rd_seq[c]      = 0;
         rd_idx[c]      = 0;
         last_accept[c] = -100;
         for (int g = 0; g < NUM_CHANNELS; g++) begin
            passes[c][g] = 0;
         end
      end

      // Outputs stay quiet through reset and into the first cycle without it.
      for (int i = 0; i < RESET_CYCLES; i++) begin
         @(posedge clock);
         #1;
         cycle++;
         assert (!o_rr.valid && o_fifo_valid == '0)
            else report_error("request or FIFO valid high around reset");
         if (i == RESET_CYCLES - 1) begin
            i_rst     = 1'b0;
            want_snap = i_from_pc_top.req_want;
         end
      end

      while (!all_done()) begin
         @(posedge clock);
         #1;
         cycle++;
         drive_cycle();
         if (cycle == STALL_START + STALL_CYCLES/2) begin
            frozen_req = req_seq[0];
            for (int c = 0; c < NUM_CHANNELS; c++) begin
               words_at_mid[c] = rd_seq[c] * BEATS + rd_idx[c];
            end
         end
         // The stalled channel must have stopped asking while the others moved on.
         if (cycle == STALL_START + STALL_CYCLES) begin
            assert (req_seq[0] == frozen_req)
               else report_error("stalled channel kept receiving requests");
            for (int c = 1; c < NUM_CHANNELS; c++) begin
               assert (rd_seq[c] * BEATS + rd_idx[c] > words_at_mid[c]
                       || rd_seq[c] >= BLOCKS_PER_CHAN)
                  else report_error($sformatf("channel %0d made no progress", c));
            end
         end
      end

      $display("sim passed");
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Watchdog expired before every channel delivered its blocks");
      $display("sim failed");
      $fatal(1, "timeout");
   end

endmodule
